/* rtl/cba_pkg.sv */
// Content addressing head: shared sizes, fixed-point widths and stream types
package cba_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  // Memory rows per query (I) and elements per row (J)
  localparam int ROWS = 8;
  localparam int COLS = 4;

  localparam int IDX_W = $clog2(ROWS);
  localparam int ACC_W = $clog2(COLS);

  //////////////////////////////////////////////////////////////////////
  // Fixed-point widths
  //////////////////////////////////////////////////////////////////////

  // Dot product of J signed 8-bit pairs, magnitude up to 65536
  localparam int DOT_W      = 18;
  // Sum of J squares, up to 65536
  localparam int NORM_W     = 17;
  // Square root over a 64-bit radicand, two bits per step
  localparam int SQRT_STEPS = 32;
  localparam int ROOT_W     = 32;
  // beta times cosine, within +-1792
  localparam int PROD_W     = 13;
  // Sum of ROWS weights of at most 2^23 each
  localparam int SUM_W      = 27;
  // Q0.16 result, one is 65536
  localparam int C_W        = 17;
  localparam int C_ONE      = 65536;
  // Q1.8 cosine, one is 256
  localparam int COS_ONE    = 256;

  // Divider widths
  localparam int DIV_COS_W = 32;
  localparam int DIV_SMX_W = 40;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic signed [7:0] elem_t;
  typedef logic [2:0]        beta_t;
  typedef logic signed [9:0] cos_t;
  typedef logic [23:0]       weight_t;
  typedef logic [IDX_W-1:0]  idx_t;

  typedef struct packed {
    elem_t [COLS-1:0] e;
  } vec_t;

  typedef struct packed {
    vec_t  key;
    beta_t beta;
  } query_t;

  typedef struct packed {
    vec_t data;
    logic last;
  } row_t;

  typedef struct packed {
    cos_t  cos;
    beta_t beta;
    logic  last;
  } sim_t;

  typedef struct packed {
    weight_t weight;
    logic    last;
  } weight_beat_t;

  typedef struct packed {
    logic [C_W-1:0] c;
    idx_t           index;
    logic           last;
  } result_t;

endpackage

/* rtl/serial_divider.sv */
// Unsigned restoring divider, one quotient bit per cycle, MSB first
`timescale 1ns/1ns

module serial_divider #(
  parameter int WIDTH = 32
) (
  input  logic             CLK,
  input  logic             RST,
  input  logic             start,
  input  logic [WIDTH-1:0] dividend,
  input  logic [WIDTH-1:0] divisor,
  output logic             busy,
  output logic             done,
  output logic [WIDTH-1:0] quotient
);

  localparam int CNT_W = $clog2(WIDTH + 1);

  logic [CNT_W-1:0] cnt;
  logic [WIDTH-1:0] rem;
  logic [WIDTH-1:0] dsor;
  logic [WIDTH:0]   rem_sh;
  logic [WIDTH:0]   diff;

  // Partial remainder takes the next dividend bit from the quotient MSB
  assign rem_sh = {rem, quotient[WIDTH-1]};
  assign diff   = rem_sh - {1'b0, dsor};

  // Step counter, done one cycle after the last step
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy <= 1'b0;
      done <= 1'b0;
      cnt  <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        cnt  <= CNT_W'(WIDTH);
      end else if (busy) begin
        if (cnt == '0) begin
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          cnt <= cnt - 1'b1;
        end
      end
    end
  end

  // Dividend shifts out as quotient bits shift in
  always_ff @(posedge CLK) begin
    if (start) begin
      rem      <= '0;
      quotient <= dividend;
      dsor     <= divisor;
    end else if (busy && cnt != '0) begin
      if (!diff[WIDTH]) begin
        rem      <= diff[WIDTH-1:0];
        quotient <= {quotient[WIDTH-2:0], 1'b1};
      end else begin
        rem      <= rem_sh[WIDTH-1:0];
        quotient <= {quotient[WIDTH-2:0], 1'b0};
      end
    end
  end

  // Callers wait for done before the next operand
  a_no_restart: assert property (@(posedge CLK) disable iff (RST) start |-> !busy)
    else $error("divider restarted while busy");

endmodule

/* rtl/cosine_similarity.sv */
// Cosine stage: per row dot product and norms, integer square root, Q1.8 divide
`timescale 1ns/1ns

module cosine_similarity (
  input  logic             CLK,
  input  logic             RST,
  input  cba_pkg::query_t  query,
  input  logic             query_valid,
  output logic             query_ready,
  input  cba_pkg::row_t    row,
  input  logic             row_valid,
  output logic             row_ready,
  output cba_pkg::sim_t    sim,
  output logic             sim_valid,
  input  logic             sim_ready
);

  import cba_pkg::*;

  typedef enum logic [2:0] {ST_IDLE, ST_ACC, ST_SQRT, ST_DIV, ST_WAIT, ST_EMIT} state_t;

  state_t                          state;
  logic                            run;
  logic                            key_full;
  logic                            row_full;
  query_t                          key_q;
  row_t                            row_q;
  logic [ACC_W-1:0]                acc_cnt;
  logic [$clog2(SQRT_STEPS)-1:0]   sq_cnt;
  logic signed [DOT_W-1:0]         dot;
  logic [NORM_W-1:0]               nk;
  logic [NORM_W-1:0]               nm;
  logic signed [15:0]              p_km;
  logic [15:0]                     p_kk;
  logic [15:0]                     p_mm;
  logic [2*SQRT_STEPS-1:0]         norm_prod;
  logic [ROOT_W-1:0]               root;
  logic [ROOT_W+1:0]               rem;
  logic [ROOT_W+3:0]               rem_sh;
  logic [ROOT_W+3:0]               trial;
  logic [NORM_W-1:0]               dot_mag;
  logic [8:0]                      cos_mag;
  logic                            div_start;
  logic                            div_busy;
  logic                            div_done;
  logic [DIV_COS_W-1:0]            div_q;

  //////////////////////////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////////////////////////

  // One key and one row held at a time
  assign query_ready = run && !key_full;
  assign row_ready   = run && !row_full;
  assign sim_valid   = (state == ST_EMIT);
  assign div_start   = (state == ST_DIV) && !div_busy;

  //////////////////////////////////////////////////////////////////////
  // Arithmetic
  //////////////////////////////////////////////////////////////////////

  // One element pair per accumulate cycle
  assign p_km = $signed(key_q.key.e[acc_cnt]) * $signed(row_q.data.e[acc_cnt]);
  assign p_kk = $signed(key_q.key.e[acc_cnt]) * $signed(key_q.key.e[acc_cnt]);
  assign p_mm = $signed(row_q.data.e[acc_cnt]) * $signed(row_q.data.e[acc_cnt]);

  assign norm_prod = (2*SQRT_STEPS)'(nk) * (2*SQRT_STEPS)'(nm);

  // Digit-by-digit root, radicand pairs taken MSB first
  assign rem_sh = {rem, norm_prod[{sq_cnt, 1'b0} +: 2]};
  assign trial  = {2'b00, root, 2'b01};

  assign dot_mag = dot[DOT_W-1] ? NORM_W'(-dot) : NORM_W'(dot);

  // Zero norm gives cos 0, floor root may push the ratio past one
  assign cos_mag = (norm_prod == '0) ? 9'd0 :
                   (div_q > DIV_COS_W'(COS_ONE)) ? 9'(COS_ONE) : div_q[8:0];

  serial_divider #(
    .WIDTH(DIV_COS_W)
  ) i_serial_divider (
    .CLK     (CLK),
    .RST     (RST),
    .start   (div_start),
    .dividend(DIV_COS_W'({dot_mag, 8'b0})),
    .divisor (root),
    .busy    (div_busy),
    .done    (div_done),
    .quotient(div_q)
  );

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= ST_IDLE;
      run      <= 1'b0;
      key_full <= 1'b0;
      row_full <= 1'b0;
      acc_cnt  <= '0;
      sq_cnt   <= '0;
    end else begin
      run <= 1'b1;
      if (query_valid && query_ready) key_full <= 1'b1;
      if (row_valid && row_ready) row_full <= 1'b1;
      case (state)
        ST_IDLE: begin
          acc_cnt <= '0;
          if (key_full && row_full) state <= ST_ACC;
        end
        ST_ACC: begin
          acc_cnt <= acc_cnt + 1'b1;
          if (acc_cnt == ACC_W'(COLS - 1)) begin
            state  <= ST_SQRT;
            sq_cnt <= $bits(sq_cnt)'(SQRT_STEPS - 1);
          end
        end
        ST_SQRT: begin
          sq_cnt <= sq_cnt - 1'b1;
          if (sq_cnt == '0) state <= ST_DIV;
        end
        ST_DIV:  if (div_start) state <= ST_WAIT;
        ST_WAIT: if (div_done) state <= ST_EMIT;
        ST_EMIT: begin
          // Key is released with the last row's result
          if (sim_ready) begin
            state    <= ST_IDLE;
            row_full <= 1'b0;
            if (row_q.last) key_full <= 1'b0;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (query_valid && query_ready) key_q <= query;
    if (row_valid && row_ready) row_q <= row;
    case (state)
      ST_IDLE: begin
        dot  <= '0;
        nk   <= '0;
        nm   <= '0;
        root <= '0;
        rem  <= '0;
      end
      ST_ACC: begin
        dot <= dot + p_km;
        nk  <= nk + NORM_W'(p_kk);
        nm  <= nm + NORM_W'(p_mm);
      end
      ST_SQRT: begin
        if (rem_sh >= trial) begin
          rem  <= (ROOT_W+2)'(rem_sh - trial);
          root <= {root[ROOT_W-2:0], 1'b1};
        end else begin
          rem  <= rem_sh[ROOT_W+1:0];
          root <= {root[ROOT_W-2:0], 1'b0};
        end
      end
      ST_WAIT: begin
        // Sign of the dot product goes back on
        if (div_done) begin
          sim.cos  <= dot[DOT_W-1] ? -cos_t'(cos_mag) : cos_t'(cos_mag);
          sim.beta <= key_q.beta;
          sim.last <= row_q.last;
        end
      end
      default: ;
    endcase
  end

endmodule

/* rtl/scaled_exponentiator.sv */
// Exponentiator: beta times cosine, then base-2 weight with linear fraction
`timescale 1ns/1ns

module scaled_exponentiator (
  input  logic                  CLK,
  input  logic                  RST,
  input  cba_pkg::sim_t         sim,
  input  logic                  sim_valid,
  output logic                  sim_ready,
  output cba_pkg::weight_beat_t weight,
  output logic                  weight_valid,
  input  logic                  weight_ready
);

  import cba_pkg::*;

  logic                     s1_valid;
  logic signed [PROD_W-1:0] x_q;
  logic                     last_q;
  logic signed [4:0]        n;
  logic [7:0]               f;
  logic signed [5:0]        shift;

  // Single item in flight across both stages
  assign sim_ready = !s1_valid && !weight_valid;

  // x = 256n + f, n by arithmetic shift
  assign n     = $signed(x_q[PROD_W-1:8]);
  assign f     = x_q[7:0];
  assign shift = n + 6'sd7;

  //////////////////////////////////////////////////////////////////////
  // Valids
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid     <= 1'b0;
      weight_valid <= 1'b0;
    end else begin
      s1_valid <= sim_valid && sim_ready;
      // Held until the softmax stage takes it
      if (s1_valid) begin
        weight_valid <= 1'b1;
      end else if (weight_ready) begin
        weight_valid <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Payload
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    // Stage 1, beta product
    if (sim_valid && sim_ready) begin
      x_q    <= $signed({1'b0, sim.beta}) * sim.cos;
      last_q <= sim.last;
    end
    // Stage 2, (256 + f) << (n + 7)
    if (s1_valid) begin
      weight.weight <= weight_t'({1'b1, f}) << shift[3:0];
      weight.last   <= last_q;
    end
  end

  // Depends on the cosine clamp upstream and beta of 7 or less
  a_shift_range: assert property (@(posedge CLK) disable iff (RST)
    s1_valid |-> (shift >= 0 && shift <= 14))
    else $error("exponent shift out of range");

endmodule

/* rtl/vector_softmax.sv */
// Softmax stage: two weight banks, each weight divided by its query's sum
`timescale 1ns/1ns

module vector_softmax (
  input  logic                  CLK,
  input  logic                  RST,
  input  cba_pkg::weight_beat_t weight,
  input  logic                  weight_valid,
  output logic                  weight_ready,
  output cba_pkg::result_t      result,
  output logic                  result_valid,
  input  logic                  result_ready
);

  import cba_pkg::*;

  typedef enum logic [1:0] {DR_IDLE, DR_DIV, DR_OUT} drain_t;

  drain_t               drain;
  weight_t              mem [2][ROWS];
  logic [SUM_W-1:0]     sum [2];
  logic [1:0]           bank_full;
  logic                 wr_bank;
  logic                 rd_bank;
  idx_t                 wr_idx;
  idx_t                 rd_idx;
  logic                 fill;
  logic                 div_start;
  logic                 div_busy;
  logic                 div_done;
  logic [DIV_SMX_W-1:0] div_q;

  // Fill bank only stalls when the drain side still owns it
  assign weight_ready = !bank_full[wr_bank];
  assign fill         = weight_valid && weight_ready;
  assign result_valid = (drain == DR_OUT);
  assign div_start    = (drain == DR_IDLE) && bank_full[rd_bank] && !div_busy;

  // weight * 65536 / S
  serial_divider #(
    .WIDTH(DIV_SMX_W)
  ) i_serial_divider (
    .CLK     (CLK),
    .RST     (RST),
    .start   (div_start),
    .dividend({mem[rd_bank][rd_idx], 16'b0}),
    .divisor (DIV_SMX_W'(sum[rd_bank])),
    .busy    (div_busy),
    .done    (div_done),
    .quotient(div_q)
  );

  //////////////////////////////////////////////////////////////////////
  // Bank control
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      drain     <= DR_IDLE;
      bank_full <= '0;
      wr_bank   <= 1'b0;
      rd_bank   <= 1'b0;
      wr_idx    <= '0;
      rd_idx    <= '0;
    end else begin
      // Fill side closes a bank on weight.last
      if (fill) begin
        if (weight.last) begin
          bank_full[wr_bank] <= 1'b1;
          wr_bank            <= !wr_bank;
          wr_idx             <= '0;
        end else begin
          wr_idx <= wr_idx + 1'b1;
        end
      end
      // Drain side, one division per result
      case (drain)
        DR_IDLE: if (div_start) drain <= DR_DIV;
        DR_DIV:  if (div_done) drain <= DR_OUT;
        DR_OUT: begin
          if (result_ready) begin
            drain <= DR_IDLE;
            if (result.last) begin
              bank_full[rd_bank] <= 1'b0;
              rd_bank            <= !rd_bank;
              rd_idx             <= '0;
            end else begin
              rd_idx <= rd_idx + 1'b1;
            end
          end
        end
        default: drain <= DR_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Storage and result register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (fill) begin
      mem[wr_bank][wr_idx] <= weight.weight;
      // Running sum restarts with the first row of a query
      sum[wr_bank] <= (wr_idx == '0) ? SUM_W'(weight.weight) :
                                       sum[wr_bank] + SUM_W'(weight.weight);
    end
    if (div_done) begin
      result.c     <= div_q[C_W-1:0];
      result.index <= rd_idx;
      result.last  <= (rd_idx == IDX_W'(ROWS - 1));
    end
  end

  // Each weight is part of its own sum
  a_c_bound: assert property (@(posedge CLK) disable iff (RST)
    result_valid |-> result.c <= C_W'(C_ONE))
    else $error("softmax weight above one");

endmodule

/* rtl/content_addressing.sv */
// Content addressing head: cosine, scaled exponential and softmax in a chain
`timescale 1ns/1ns

module content_addressing (
  input  logic             CLK,
  input  logic             RST,
  input  cba_pkg::query_t  query,
  input  logic             query_valid,
  output logic             query_ready,
  input  cba_pkg::row_t    row,
  input  logic             row_valid,
  output logic             row_ready,
  output cba_pkg::result_t result,
  output logic             result_valid,
  input  logic             result_ready
);

  import cba_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Inter-stage streams
  //////////////////////////////////////////////////////////////////////

  // Cosine to exponentiator
  sim_t         sim;
  logic         sim_valid;
  logic         sim_ready;

  // Exponentiator to softmax
  weight_beat_t weight;
  logic         weight_valid;
  logic         weight_ready;

  //////////////////////////////////////////////////////////////////////
  // Stages
  //////////////////////////////////////////////////////////////////////

  cosine_similarity i_cosine_similarity (
    .CLK        (CLK),
    .RST        (RST),
    .query      (query),
    .query_valid(query_valid),
    .query_ready(query_ready),
    .row        (row),
    .row_valid  (row_valid),
    .row_ready  (row_ready),
    .sim        (sim),
    .sim_valid  (sim_valid),
    .sim_ready  (sim_ready)
  );

  // Beta multiply sits at the front of the exponentiator
  scaled_exponentiator i_scaled_exponentiator (
    .CLK         (CLK),
    .RST         (RST),
    .sim         (sim),
    .sim_valid   (sim_valid),
    .sim_ready   (sim_ready),
    .weight      (weight),
    .weight_valid(weight_valid),
    .weight_ready(weight_ready)
  );

  vector_softmax i_vector_softmax (
    .CLK         (CLK),
    .RST         (RST),
    .weight      (weight),
    .weight_valid(weight_valid),
    .weight_ready(weight_ready),
    .result      (result),
    .result_valid(result_valid),
    .result_ready(result_ready)
  );

endmodule

/* bench/cba_model.svh */
// Reference model for the content addressing head: LFSR, cosine, exponential and softmax
`ifndef CBA_MODEL_SVH
`define CBA_MODEL_SVH

  ////////////////////////////////////////////////////////////////////////
  // Random source
  ////////////////////////////////////////////////////////////////////////

  // 16-bit Galois LFSR, taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  ////////////////////////////////////////////////////////////////////////
  // Rule 1, cosine in Q1.8
  ////////////////////////////////////////////////////////////////////////

  // Largest r with r*r <= x, x at most 2^32
  function automatic longint floor_sqrt(input longint x);
    longint lo;
    longint hi;
    longint mid;
    lo = 0;
    hi = 65536;
    while (lo < hi) begin
      mid = (lo + hi + 1) / 2;
      if (mid * mid <= x) lo = mid;
      else hi = mid - 1;
    end
    return lo;
  endfunction

  function automatic int cos_ref(input vec_t k, input vec_t m);
    int     dot;
    int     nk;
    int     nm;
    int     a;
    int     b;
    int     mag;
    longint root;
    dot = 0;
    nk  = 0;
    nm  = 0;
    for (int j = 0; j < COLS; j++) begin
      a = k.e[j];
      b = m.e[j];
      dot += a * b;
      nk  += a * a;
      nm  += b * b;
    end
    // Zero vector on either side
    if (nk == 0 || nm == 0) return 0;
    root = floor_sqrt(longint'(nk) * longint'(nm));
    mag  = int'((longint'(dot < 0 ? -dot : dot) * 256) / root);
    if (mag > 256) mag = 256;
    return (dot < 0) ? -mag : mag;
  endfunction

  ////////////////////////////////////////////////////////////////////////
  // Rules 2 and 3
  ////////////////////////////////////////////////////////////////////////

  // Base-2 exponential, linear between integer powers
  function automatic longint weight_ref(input int beta, input int cosv);
    int x;
    int n;
    int f;
    x = beta * cosv;
    n = x >>> 8;
    f = x - 256 * n;
    return longint'(256 + f) << (n + 7);
  endfunction

  // Q0.16 share of the query sum
  function automatic int c_ref(input longint w, input longint s);
    return int'((w * 65536) / s);
  endfunction

`endif

/* bench/content_addressing_tb.sv */
// Testbench for the content addressing head: directed, random and back-pressure queries
`timescale 1ns/1ns

module content_addressing_tb;

  import cba_pkg::*;

  `include "cba_model.svh"

  // Handshake and drain limits in clock cycles
  localparam int HS_LIMIT    = 4000;
  localparam int DRAIN_LIMIT = 20000;

  logic        CLK;
  logic        RST;
  query_t      query;
  logic        query_valid;
  logic        query_ready;
  row_t        row;
  logic        row_valid;
  logic        row_ready;
  result_t     result;
  logic        result_valid;
  logic        result_ready;

  logic [15:0] data_lfsr;
  logic [15:0] bp_lfsr;
  logic        bp_en;
  int          errors;
  int          timeouts;
  int          n_results;
  int          query_sum;
  result_t     exp_q[$];
  result_t     got_q[$];

  content_addressing i_content_addressing (
    .CLK         (CLK),
    .RST         (RST),
    .query       (query),
    .query_valid (query_valid),
    .query_ready (query_ready),
    .row         (row),
    .row_valid   (row_valid),
    .row_ready   (row_ready),
    .result      (result),
    .result_valid(result_valid),
    .result_ready(result_ready)
  );

  // 40 ns clock
  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////

  // n bits, LSB of the LFSR each step, first bit ends up on top
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], data_lfsr[0]};
      data_lfsr = lfsr_next(data_lfsr);
    end
    return v;
  endfunction

  function automatic vec_t rand_vec();
    vec_t v;
    for (int j = 0; j < COLS; j++) begin
      v.e[j] = elem_t'(rand_bits(8));
    end
    return v;
  endfunction

  // Expected results from rules 1 to 3
  task automatic push_model(input query_t q, input vec_t [ROWS-1:0] rows);
    longint  w[ROWS];
    longint  s;
    result_t r;
    s = 0;
    for (int i = 0; i < ROWS; i++) begin
      w[i] = weight_ref(int'(q.beta), cos_ref(q.key, rows[i]));
      s += w[i];
    end
    for (int i = 0; i < ROWS; i++) begin
      r.c     = C_W'(c_ref(w[i], s));
      r.index = idx_t'(i);
      r.last  = (i == ROWS - 1);
      exp_q.push_back(r);
    end
  endtask

  // Equal weights, one eighth each
  task automatic push_uniform();
    result_t r;
    for (int i = 0; i < ROWS; i++) begin
      r.c     = C_W'(8192);
      r.index = idx_t'(i);
      r.last  = (i == ROWS - 1);
      exp_q.push_back(r);
    end
  endtask

  // Ready sampled mid-cycle, transfer on the next rising edge
  task automatic await_accept(input logic use_row, output logic taken);
    int t;
    taken = 1'b0;
    t = 0;
    while (!taken && t < HS_LIMIT) begin
      @(negedge CLK);
      taken = use_row ? row_ready : query_ready;
      @(posedge CLK);
      #2;
      t++;
    end
  endtask

  task automatic send_query(input query_t q, input vec_t [ROWS-1:0] rows, input bit uniform);
    logic taken;
    if (timeouts > 0) return;
    if (uniform) push_uniform();
    else push_model(q, rows);
    query       = q;
    query_valid = 1'b1;
    await_accept(1'b0, taken);
    query_valid = 1'b0;
    if (!taken) begin
      timeouts++;
      $display("Timeout: query was never accepted at %0t", $time);
      return;
    end
    // Rows back to back, last flag on the final one
    for (int i = 0; i < ROWS; i++) begin
      row.data  = rows[i];
      row.last  = (i == ROWS - 1);
      row_valid = 1'b1;
      await_accept(1'b1, taken);
      row_valid = 1'b0;
      if (!taken) begin
        timeouts++;
        $display("Timeout: row %0d was never accepted at %0t", i, $time);
        return;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////

  task automatic check_idle(input logic exp_rv, input logic exp_qr, input logic exp_rr);
    if (result_valid !== exp_rv || query_ready !== exp_qr || row_ready !== exp_rr) begin
      errors++;
      $display("Error at %0t: result_valid %b query_ready %b row_ready %b, expected %b %b %b",
               $time, result_valid, query_ready, row_ready, exp_rv, exp_qr, exp_rr);
    end
  endtask

  task automatic check_result(input result_t got, input result_t exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: c %0d index %0d last %b, expected c %0d index %0d last %b",
               $time, got.c, got.index, got.last, exp.c, exp.index, exp.last);
    end
  endtask

  // Floor rounding loses at most one count per row
  task automatic check_sum(input int sum);
    if (sum < 65529 || sum > 65536) begin
      errors++;
      $display("Error at %0t: query weights sum to %0d, outside 65529 to 65536", $time, sum);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Result side
  ////////////////////////////////////////////////////////////////////////

  // Random back-pressure once enabled
  initial begin
    bp_lfsr = 16'd2;
    forever begin
      @(posedge CLK);
      #2;
      if (bp_en) begin
        result_ready = bp_lfsr[0];
        bp_lfsr = lfsr_next(bp_lfsr);
      end else begin
        result_ready = 1'b1;
      end
    end
  end

  // Monitor, valid and ready both settled at the falling edge
  initial begin
    forever begin
      @(negedge CLK);
      if (!RST && result_valid && result_ready) got_q.push_back(result);
    end
  end

  // In-order compare against the expected queue
  initial begin
    result_t got;
    result_t exp;
    query_sum = 0;
    forever begin
      @(posedge CLK);
      while (got_q.size() > 0) begin
        got = got_q.pop_front();
        n_results++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Error at %0t: unexpected result index %0d", $time, got.index);
        end else begin
          exp = exp_q.pop_front();
          check_result(got, exp);
        end
        query_sum += int'(got.c);
        if (got.last) begin
          check_sum(query_sum);
          query_sum = 0;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////

  initial begin
    query_t            q;
    vec_t [ROWS-1:0]   rows;
    int                t;
    RST          = 1'b1;
    query        = '0;
    query_valid  = 1'b0;
    row          = '0;
    row_valid    = 1'b0;
    result_ready = 1'b1;
    bp_en        = 1'b0;
    data_lfsr    = 16'd2;
    errors       = 0;
    timeouts     = 0;
    n_results    = 0;

    // Readies held low through reset
    repeat (8) @(posedge CLK);
    #2;
    check_idle(1'b0, 1'b0, 1'b0);
    repeat (8) @(posedge CLK);
    #2;
    RST = 1'b0;
    repeat (2) @(posedge CLK);
    #2;
    check_idle(1'b0, 1'b1, 1'b1);

    // Key equal to every row, cos one, beta 3
    q.key      = rand_vec();
    q.key.e[0] = 8'sd64;
    q.beta     = 3'd3;
    for (int i = 0; i < ROWS; i++) rows[i] = q.key;
    send_query(q, rows, 1'b1);

    // Beta 0 flattens any rows
    q.key  = rand_vec();
    q.beta = 3'd0;
    for (int i = 0; i < ROWS; i++) rows[i] = rand_vec();
    send_query(q, rows, 1'b1);

    // Zero row in a sharp query
    q.key  = rand_vec();
    q.beta = 3'd5;
    for (int i = 0; i < ROWS; i++) rows[i] = rand_vec();
    rows[3] = '0;
    send_query(q, rows, 1'b0);

    // Random keys, rows and beta
    for (int n = 0; n < 20; n++) begin
      q.key  = rand_vec();
      q.beta = beta_t'(rand_bits(3));
      for (int i = 0; i < ROWS; i++) rows[i] = rand_vec();
      send_query(q, rows, 1'b0);
    end

    // Back-to-back queries under result stalls
    bp_en = 1'b1;
    for (int n = 0; n < 8; n++) begin
      q.key  = rand_vec();
      q.beta = beta_t'(rand_bits(3));
      for (int i = 0; i < ROWS; i++) rows[i] = rand_vec();
      send_query(q, rows, 1'b0);
    end

    // Drain outstanding results
    if (timeouts == 0) begin
      t = 0;
      while (exp_q.size() > 0 && t < DRAIN_LIMIT) begin
        @(negedge CLK);
        t++;
      end
      if (exp_q.size() > 0) begin
        timeouts++;
        $display("Timeout: %0d expected results never arrived", exp_q.size());
      end
    end
    // Quiet tail catches extra results
    repeat (100) @(negedge CLK);

    $display("Results compared: %0d, errors: %0d, timeouts: %0d", n_results, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+bench
rtl/cba_pkg.sv
rtl/serial_divider.sv
rtl/cosine_similarity.sv
rtl/scaled_exponentiator.sv
rtl/vector_softmax.sv
rtl/content_addressing.sv
bench/content_addressing_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the content addressing testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f \
  --top-module content_addressing_tb \
  --Mdir obj_dir -o content_addressing_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/content_addressing_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1
